//--- compile.f
+incdir+hw
hw/lc3b_types.sv
hw/lc3b_regfile.sv
hw/lc3b_forward.sv
hw/lc3b_divmult.sv
hw/lc3b_decode.sv
hw/lc3b_execute.sv
hw/lc3b_result.sv
hw/lc3b_core.sv
tests/tb_clock.sv
tests/tb_lc3b_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_lc3b_core
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard hw/*.svh)
BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_defs.svh"

module tb_lc3b_core;

	localparam int N_ALU = 200;
	localparam int N_SHF = 100;
	localparam int N_FWD = 30;
	localparam int N_MD = 60;
	localparam int N_BP = 80;
	// Each MUL/DIV has a dependent follower, every tenth also a zeroing AND.
	localparam int MD_SENT = 2 * N_MD + N_MD / 10;
	localparam int TOTAL_SENT = 8 + N_ALU + N_SHF + 3 * N_FWD + MD_SENT + N_BP;
	localparam int CYCLES_PER_INSTR = 400;

	logic clk;
	logic rst_n;
	logic instr_req;
	lc3b_types::lc3b_instr instr;
	logic instr_ack;
	logic result_req;
	logic [2:0] result_dr;
	lc3b_types::lc3b_word result_val;
	logic result_ack;

	logic [31:0] stim_rng;
	logic [31:0] ack_rng;
	int ack_max_delay;
	lc3b_types::lc3b_word model_regs [8];
	logic [2:0] recent_dst [3];
	logic [18:0] expected_q [$];
	string test_name;
	int result_errors;
	int results_checked;
	int other_errors;
	int err_base;
	int chk_base;
	int tests_run;
	int tests_failed;

	tb_clock u_clock (
		.clk(clk)
	);

	lc3b_core UUT (
		.clk(clk),
		.rst_n(rst_n),
		.instr_req(instr_req),
		.instr(instr),
		.instr_ack(instr_ack),
		.result_req(result_req),
		.result_dr(result_dr),
		.result_val(result_val),
		.result_ack(result_ack)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] stim_next();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	// Sources lean toward the last three destinations.
	function automatic logic [2:0] pick_src();
		logic [31:0] r;
		r = stim_next();
		if (r[5:4] == 2'd3) begin
			return r[10:8];
		end
		return recent_dst[r[5:4]];
	endfunction

	function automatic logic [15:0] gen_alu();
		logic [31:0] r;
		logic [3:0] op;
		logic [2:0] sr1;
		logic [4:0] low5;
		r = stim_next();
		sr1 = pick_src();
		if (r[2:0] < 3'd3) begin
			op = `LC3B_OP_ADD;
		end else if (r[2:0] < 3'd5) begin
			op = `LC3B_OP_AND;
		end else begin
			op = `LC3B_OP_XOR;
		end
		if (r[2:0] == 3'd7) begin
			// NOT form.
			return {op, r[10:8], sr1, 1'b1, 5'b11111};
		end
		if (r[3]) begin
			return {op, r[10:8], sr1, 1'b1, r[20:16]};
		end
		low5 = {2'b00, pick_src()};
		return {op, r[10:8], sr1, 1'b0, low5};
	endfunction

	function automatic logic [15:0] gen_shf();
		logic [31:0] r;
		logic [2:0] sr1;
		r = stim_next();
		sr1 = pick_src();
		return {`LC3B_OP_SHF, r[2:0], sr1, r[5:4], r[11:8]};
	endfunction

	function automatic logic [15:0] gen_md();
		logic [31:0] r;
		logic [2:0] sr1;
		logic [2:0] sr2;
		r = stim_next();
		sr1 = pick_src();
		sr2 = pick_src();
		return {r[0] ? `LC3B_OP_DIV : `LC3B_OP_MUL, r[3:1], sr1, 3'b000, sr2};
	endfunction

	// Moves a kept opcode to a neighbour outside the kept set.
	function automatic logic [3:0] noop_opcode(input logic [3:0] sel);
		case (sel)
			`LC3B_OP_ADD, `LC3B_OP_AND, `LC3B_OP_XOR, `LC3B_OP_SHF: return sel ^ 4'b0001;
			`LC3B_OP_MUL, `LC3B_OP_DIV: return sel ^ 4'b0100;
			default: return sel;
		endcase
	endfunction

	// Architectural effect of one instruction.
	task automatic model_step(input logic [15:0] w);
		lc3b_types::lc3b_word a;
		lc3b_types::lc3b_word b;
		lc3b_types::lc3b_word res;
		logic [31:0] prod;
		logic [3:0] amt;
		logic writes;
		a = model_regs[w[8:6]];
		b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
		amt = w[3:0];
		writes = 1'b1;
		res = '0;
		case (w[15:12])
			`LC3B_OP_ADD: res = a + b;
			`LC3B_OP_AND: res = a & b;
			`LC3B_OP_XOR: res = a ^ b;
			`LC3B_OP_SHF: begin
				if (!w[4]) begin
					res = a << amt;
				end else if (!w[5]) begin
					res = a >> amt;
				end else begin
					res = (a >> amt) | (a[15] ? ~(16'hffff >> amt) : 16'h0000);
				end
			end
			`LC3B_OP_MUL: begin
				prod = {16'd0, a} * {16'd0, model_regs[w[2:0]]};
				res = prod[15:0];
			end
			`LC3B_OP_DIV: begin
				b = model_regs[w[2:0]];
				res = (b == 16'd0) ? 16'hffff : a / b;
			end
			default: writes = 1'b0;
		endcase
		if (writes) begin
			model_regs[w[11:9]] = res;
			expected_q.push_back({w[11:9], res});
			recent_dst[2] = recent_dst[1];
			recent_dst[1] = recent_dst[0];
			recent_dst[0] = w[11:9];
		end
	endtask

	task automatic send_instr(input logic [15:0] w);
		model_step(w);
		@(negedge clk);
		instr = w;
		instr_req = 1'b1;
		@(negedge clk);
		while (!instr_ack) begin
			@(negedge clk);
		end
		instr_req = 1'b0;
		while (instr_ack) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0 || result_req || result_ack) begin
			@(negedge clk);
		end
		// Idle window, so a late extra result still shows up.
		repeat (20) @(negedge clk);
	endtask

	task automatic start_test(input string name, input int max_delay);
		test_name = name;
		ack_max_delay = max_delay;
		err_base = result_errors + other_errors;
		chk_base = results_checked;
	endtask

	task automatic finish_test();
		int errs;
		int chks;
		errs = result_errors + other_errors - err_base;
		chks = results_checked - chk_base;
		tests_run++;
		if (errs == 0) begin
			$display("%s: ok, %0d results checked", test_name, chks);
		end else begin
			tests_failed++;
			$display("%s: %0d errors, %0d results checked", test_name, errs, chks);
		end
	endtask

	// Result side of the four-phase port, with a random ack delay.
	initial begin : result_side
		int delay;
		logic [18:0] exp_item;
		result_ack = 1'b0;
		ack_rng = 32'd57837 ^ 32'ha5a5_5a5a;
		results_checked = 0;
		result_errors = 0;
		forever begin
			@(negedge clk);
			if (result_req && !result_ack) begin
				results_checked++;
				if (expected_q.size() == 0) begin
					$display("%s: result for r%0d arrived with no writing instruction pending",
						test_name, result_dr);
					result_errors++;
				end else begin
					exp_item = expected_q.pop_front();
					if (result_dr !== exp_item[18:16] || result_val !== exp_item[15:0]) begin
						$display("Fail %s: expected r%0d = %h, actual r%0d = %h", test_name,
							exp_item[18:16], exp_item[15:0], result_dr, result_val);
						result_errors++;
					end
				end
				ack_rng = xorshift(ack_rng);
				delay = int'(ack_rng % 32'(ack_max_delay + 1));
				repeat (delay) @(negedge clk);
				result_ack = 1'b1;
				@(negedge clk);
				while (result_req) begin
					@(negedge clk);
				end
				result_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (TOTAL_SENT * CYCLES_PER_INSTR) @(posedge clk);
		$display("Timeout: the DUT stopped responding before all tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin : stimulus
		logic [15:0] w;
		logic [31:0] r;
		logic [2:0] rz;
		rst_n = 1'b0;
		instr_req = 1'b0;
		instr = '0;
		stim_rng = 32'd57837;
		other_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		ack_max_delay = 2;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = '0;
		end
		recent_dst[0] = 3'd0;
		recent_dst[1] = 3'd1;
		recent_dst[2] = 3'd2;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		start_test("reset_state", 2);
		@(negedge clk);
		if (instr_ack !== 1'b0) begin
			$display("reset_state: instr_ack is not low after reset");
			other_errors++;
		end
		if (result_req !== 1'b0) begin
			$display("reset_state: result_req is not low after reset");
			other_errors++;
		end
		for (int i = 0; i < 8; i++) begin
			send_instr({`LC3B_OP_ADD, 3'(i), 3'(i), 1'b1, 5'b00000});
		end
		wait_drain();
		finish_test();

		start_test("alu_ops", 3);
		for (int i = 0; i < N_ALU; i++) begin
			send_instr(gen_alu());
		end
		wait_drain();
		finish_test();

		start_test("shifts", 3);
		for (int i = 0; i < N_SHF; i++) begin
			send_instr(gen_shf());
		end
		wait_drain();
		finish_test();

		// Ack delays keep the pipeline full, so the producer still sits in execute.
		start_test("forwarding", 4);
		for (int d = 0; d < 3; d++) begin
			for (int i = 0; i < N_FWD; i++) begin
				r = stim_next();
				w = gen_alu();
				// Sources tied to the destination d+1 instructions back.
				w[8:6] = recent_dst[d];
				if (!w[5]) begin
					w[2:0] = r[0] ? recent_dst[d] : recent_dst[0];
				end
				send_instr(w);
			end
		end
		wait_drain();
		finish_test();

		start_test("mul_div", 2);
		for (int i = 0; i < N_MD; i++) begin
			w = gen_md();
			if (i % 10 == 0) begin
				r = stim_next();
				rz = r[2:0];
				send_instr({`LC3B_OP_AND, rz, rz, 1'b1, 5'b00000});
				w[15:12] = `LC3B_OP_DIV;
				w[2:0] = rz;
			end
			send_instr(w);
			r = stim_next();
			send_instr({r[0] ? `LC3B_OP_ADD : `LC3B_OP_XOR, r[3:1], w[11:9], 1'b1, r[8:4]});
		end
		wait_drain();
		finish_test();

		start_test("backpressure_order", 40);
		for (int i = 0; i < N_BP; i++) begin
			r = stim_next();
			case (r[1:0])
				2'd0: begin
					w = gen_alu();
					w[15:12] = noop_opcode(r[7:4]);
				end
				2'd1: w = gen_shf();
				2'd2: w = gen_alu();
				default: w = gen_md();
			endcase
			send_instr(w);
		end
		wait_drain();
		finish_test();

		$display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
			tests_run, tests_failed, results_checked, result_errors + other_errors);
		if (result_errors + other_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD = 8.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2.0) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

//--- hw/lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_defs.svh"

module lc3b_core (
	input logic clk,
	input logic rst_n,
	input logic instr_req,
	input lc3b_types::lc3b_instr instr,
	output logic instr_ack,
	output logic result_req,
	output logic [2:0] result_dr,
	output lc3b_types::lc3b_word result_val,
	input logic result_ack
);

	logic d_valid;
	logic [2:0] d_dr;
	logic [2:0] d_sr1;
	logic [2:0] d_sr2;
	logic d_wr;
	logic [`LC3B_ALUOP_W-1:0] d_aluop;
	logic [`LC3B_OPB_W-1:0] d_opb_sel;
	lc3b_types::lc3b_word d_imm;
	lc3b_types::lc3b_word d_sr1_val;
	lc3b_types::lc3b_word d_sr2_val;
	logic x_stall;
	logic x_valid;
	logic [2:0] x_dr;
	logic x_wr;
	lc3b_types::lc3b_word x_val;
	logic r_stall;
	logic r_wr_en;
	logic [2:0] r_dr;
	lc3b_types::lc3b_word r_val;
	logic w_en;
	logic [2:0] w_dr;
	lc3b_types::lc3b_word w_val;

	lc3b_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.instr_req(instr_req),
		.instr(instr),
		.instr_ack(instr_ack),
		.x_stall(x_stall),
		.r_wr_en(r_wr_en),
		.r_dr(r_dr),
		.r_val(r_val),
		.d_valid(d_valid),
		.d_dr(d_dr),
		.d_sr1(d_sr1),
		.d_sr2(d_sr2),
		.d_wr(d_wr),
		.d_aluop(d_aluop),
		.d_opb_sel(d_opb_sel),
		.d_imm(d_imm),
		.d_sr1_val(d_sr1_val),
		.d_sr2_val(d_sr2_val)
	);

	lc3b_execute u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.d_valid(d_valid),
		.d_dr(d_dr),
		.d_sr1(d_sr1),
		.d_sr2(d_sr2),
		.d_wr(d_wr),
		.d_aluop(d_aluop),
		.d_opb_sel(d_opb_sel),
		.d_imm(d_imm),
		.d_sr1_val(d_sr1_val),
		.d_sr2_val(d_sr2_val),
		.r_stall(r_stall),
		.x_val(x_val),
		.x_dr(x_dr),
		.x_wr(x_wr),
		.x_valid(x_valid),
		.x_stall(x_stall),
		.r_val(r_val),
		.w_en(w_en),
		.w_dr(w_dr),
		.w_val(w_val)
	);

	lc3b_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.x_valid(x_valid),
		.x_wr(x_wr),
		.x_dr(x_dr),
		.x_val(x_val),
		.r_stall(r_stall),
		.r_wr_en(r_wr_en),
		.r_dr(r_dr),
		.r_val(r_val),
		.w_en(w_en),
		.w_dr(w_dr),
		.w_val(w_val),
		.result_req(result_req),
		.result_dr(result_dr),
		.result_val(result_val),
		.result_ack(result_ack)
	);

endmodule

`default_nettype wire

//--- hw/lc3b_result.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_result (
	input logic clk,
	input logic rst_n,
	input logic x_valid,
	input logic x_wr,
	input logic [2:0] x_dr,
	input lc3b_types::lc3b_word x_val,
	output logic r_stall,
	output logic r_wr_en,
	output logic [2:0] r_dr,
	output lc3b_types::lc3b_word r_val,
	output logic w_en,
	output logic [2:0] w_dr,
	output lc3b_types::lc3b_word w_val,
	output logic result_req,
	output logic [2:0] result_dr,
	output lc3b_types::lc3b_word result_val,
	input logic result_ack
);

	logic full;

	// Register file is written on the edge that takes a writer.
	assign r_wr_en = x_valid && x_wr && !full;
	assign r_dr = x_dr;
	assign r_val = x_val;
	assign r_stall = full;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full <= 1'b0;
			result_req <= 1'b0;
			w_en <= 1'b0;
		end else begin
			w_en <= r_wr_en;
			if (r_wr_en) begin
				full <= 1'b1;
				result_req <= 1'b1;
			end else if (result_req && result_ack) begin
				result_req <= 1'b0;
			end else if (full && !result_req && !result_ack) begin
				full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (r_wr_en) begin
			result_dr <= x_dr;
			result_val <= x_val;
		end
		w_dr <= r_dr;
		w_val <= r_val;
	end

endmodule

`default_nettype wire

//--- hw/lc3b_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_defs.svh"

module lc3b_execute (
	input logic clk,
	input logic rst_n,
	input logic d_valid,
	input logic [2:0] d_dr,
	input logic [2:0] d_sr1,
	input logic [2:0] d_sr2,
	input logic d_wr,
	input logic [`LC3B_ALUOP_W-1:0] d_aluop,
	input logic [`LC3B_OPB_W-1:0] d_opb_sel,
	input lc3b_types::lc3b_word d_imm,
	input lc3b_types::lc3b_word d_sr1_val,
	input lc3b_types::lc3b_word d_sr2_val,
	input logic r_stall,
	output lc3b_types::lc3b_word x_val,
	output logic [2:0] x_dr,
	output logic x_wr,
	output logic x_valid,
	output logic x_stall,
	input lc3b_types::lc3b_word r_val,
	input logic w_en,
	input logic [2:0] w_dr,
	input lc3b_types::lc3b_word w_val
);

	logic [1:0] fwd1_sel;
	logic [1:0] fwd2_sel;
	logic use_sr2;
	logic is_md;
	logic md_start;
	logic md_busy;
	logic md_done;
	logic md_wait;
	lc3b_types::lc3b_word opa;
	lc3b_types::lc3b_word src2;
	lc3b_types::lc3b_word opb;
	lc3b_types::lc3b_word alu_out;
	lc3b_types::lc3b_word md_out;

	assign use_sr2 = (d_opb_sel == `LC3B_OPB_REG);
	assign is_md = (d_aluop == `LC3B_ALU_MUL) || (d_aluop == `LC3B_ALU_DIV);

	lc3b_forward u_forward (
		.sr1(d_sr1),
		.sr2(d_sr2),
		.use_sr2(use_sr2),
		.x_valid(x_valid),
		.x_wr(x_wr),
		.x_dr(x_dr),
		.w_en(w_en),
		.w_dr(w_dr),
		.fwd1_sel(fwd1_sel),
		.fwd2_sel(fwd2_sel)
	);

	// Execute-register value arrives back as the write-port value.
	assign opa = fwd1_sel[0] ? r_val : (fwd1_sel[1] ? w_val : d_sr1_val);
	assign src2 = fwd2_sel[0] ? r_val : (fwd2_sel[1] ? w_val : d_sr2_val);
	assign opb = use_sr2 ? src2 : d_imm;

	always_comb begin
		case (d_aluop)
			`LC3B_ALU_ADD: alu_out = opa + opb;
			`LC3B_ALU_AND: alu_out = opa & opb;
			`LC3B_ALU_XOR: alu_out = opa ^ opb;
			`LC3B_ALU_SLL: alu_out = opa << opb[3:0];
			`LC3B_ALU_SRL: alu_out = opa >> opb[3:0];
			`LC3B_ALU_SRA: alu_out = $signed(opa) >>> opb[3:0];
			default: alu_out = md_out;
		endcase
	end

	assign md_start = d_valid && is_md && !md_busy && !md_done;
	assign md_wait = d_valid && is_md && !md_done;
	assign x_stall = r_stall || md_wait;

	lc3b_divmult u_divmult (
		.clk(clk),
		.rst_n(rst_n),
		.start(md_start),
		.is_div(d_aluop == `LC3B_ALU_DIV),
		.a(opa),
		.b(opb),
		.hold(r_stall),
		.busy(md_busy),
		.done(md_done),
		.solution(md_out)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_valid <= 1'b0;
		end else if (!r_stall) begin
			x_valid <= d_valid && !md_wait;
		end
	end

	always_ff @(posedge clk) begin
		if (!r_stall) begin
			x_dr <= d_dr;
			x_wr <= d_wr;
			x_val <= alu_out;
		end
	end

endmodule

`default_nettype wire

//--- hw/lc3b_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_defs.svh"

module lc3b_decode (
	input logic clk,
	input logic rst_n,
	input logic instr_req,
	input lc3b_types::lc3b_instr instr,
	output logic instr_ack,
	input logic x_stall,
	input logic r_wr_en,
	input logic [2:0] r_dr,
	input lc3b_types::lc3b_word r_val,
	output logic d_valid,
	output logic [2:0] d_dr,
	output logic [2:0] d_sr1,
	output logic [2:0] d_sr2,
	output logic d_wr,
	output logic [`LC3B_ALUOP_W-1:0] d_aluop,
	output logic [`LC3B_OPB_W-1:0] d_opb_sel,
	output lc3b_types::lc3b_word d_imm,
	output lc3b_types::lc3b_word d_sr1_val,
	output lc3b_types::lc3b_word d_sr2_val
);

	lc3b_types::lc3b_instr ir;
	logic load;

	// Accept a new word when the slot is empty or drains this cycle.
	assign load = instr_req && !instr_ack && (!d_valid || !x_stall);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr_ack <= 1'b0;
			d_valid <= 1'b0;
		end else begin
			if (load) begin
				instr_ack <= 1'b1;
			end else if (!instr_req) begin
				instr_ack <= 1'b0;
			end
			if (load) begin
				d_valid <= 1'b1;
			end else if (!x_stall) begin
				d_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			ir <= instr;
		end
	end

	assign d_dr = ir.opr.dr;
	assign d_sr1 = ir.opr.sr1;
	assign d_sr2 = ir.opr.low5[2:0];

	always_comb begin
		d_wr = 1'b1;
		d_aluop = `LC3B_ALU_ADD;
		d_opb_sel = ir.opr.imm_flag ? `LC3B_OPB_IMM5 : `LC3B_OPB_REG;
		d_imm = {{11{ir.opr.low5[4]}}, ir.opr.low5};
		case (ir.opr.opcode)
			`LC3B_OP_ADD: d_aluop = `LC3B_ALU_ADD;
			`LC3B_OP_AND: d_aluop = `LC3B_ALU_AND;
			`LC3B_OP_XOR: d_aluop = `LC3B_ALU_XOR;
			`LC3B_OP_SHF: begin
				// Shift fields come from the other view of the word.
				d_opb_sel = `LC3B_OPB_IMM4;
				d_imm = {12'd0, ir.shf.amount};
				if (!ir.shf.right) begin
					d_aluop = `LC3B_ALU_SLL;
				end else begin
					d_aluop = ir.shf.arith ? `LC3B_ALU_SRA : `LC3B_ALU_SRL;
				end
			end
			`LC3B_OP_MUL: begin
				d_aluop = `LC3B_ALU_MUL;
				d_opb_sel = `LC3B_OPB_REG;
			end
			`LC3B_OP_DIV: begin
				d_aluop = `LC3B_ALU_DIV;
				d_opb_sel = `LC3B_OPB_REG;
			end
			default: begin
				d_wr = 1'b0;
				d_opb_sel = `LC3B_OPB_REG;
			end
		endcase
	end

	lc3b_regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.rd_a(d_sr1),
		.rd_b(d_sr2),
		.val_a(d_sr1_val),
		.val_b(d_sr2_val),
		.wr_en(r_wr_en),
		.wr_dr(r_dr),
		.wr_val(r_val)
	);

endmodule

`default_nettype wire

//--- hw/lc3b_divmult.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_defs.svh"

module lc3b_divmult (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic is_div,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	input logic hold,
	output logic busy,
	output logic done,
	output lc3b_types::lc3b_word solution
);

	localparam int CNT_W = $clog2(`LC3B_MD_CYCLES);

	logic [CNT_W-1:0] count;
	logic mode_div;
	logic launch;
	lc3b_types::lc3b_word acc;
	lc3b_types::lc3b_word shreg;
	lc3b_types::lc3b_word opnd;
	logic [16:0] rem_shift;
	logic [16:0] diff;

	assign launch = start && !busy && !done;

	// Restoring step. A zero divisor never borrows, so the quotient is all ones.
	assign rem_shift = {acc, shreg[15]};
	assign diff = rem_shift - {1'b0, opnd};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else if (!hold) begin
			if (launch) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == CNT_W'(`LC3B_MD_CYCLES - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end else begin
				done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			if (launch) begin
				mode_div <= is_div;
				acc <= '0;
				opnd <= is_div ? b : a;
				shreg <= is_div ? a : b;
			end else if (busy && mode_div) begin
				acc <= diff[16] ? rem_shift[15:0] : diff[15:0];
				shreg <= {shreg[14:0], ~diff[16]};
			end else if (busy) begin
				// Shift-add on the multiplier low bit.
				if (shreg[0]) begin
					acc <= acc + opnd;
				end
				opnd <= {opnd[14:0], 1'b0};
				shreg <= {1'b0, shreg[15:1]};
			end
		end
	end

	assign solution = mode_div ? shreg : acc;

endmodule

`default_nettype wire

//--- hw/lc3b_forward.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_forward (
	input logic [2:0] sr1,
	input logic [2:0] sr2,
	input logic use_sr2,
	input logic x_valid,
	input logic x_wr,
	input logic [2:0] x_dr,
	input logic w_en,
	input logic [2:0] w_dr,
	output logic [1:0] fwd1_sel,
	output logic [1:0] fwd2_sel
);

	// Select bit 0 takes the execute register, bit 1 the last write-back.
	function automatic logic [1:0] pick(input logic [2:0] sr);
		logic [1:0] sel;
		sel = 2'b00;
		// Execute register is younger, so it is checked first.
		if (x_valid && x_wr && (x_dr == sr)) begin
			sel = 2'b01;
		end else if (w_en && (w_dr == sr)) begin
			sel = 2'b10;
		end
		return sel;
	endfunction

	always_comb begin
		fwd1_sel = pick(sr1);
	end

	always_comb begin
		if (use_sr2) begin
			fwd2_sel = pick(sr2);
		end else begin
			fwd2_sel = 2'b00;
		end
	end

endmodule

`default_nettype wire

//--- hw/lc3b_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_regfile (
	input logic clk,
	input logic rst_n,
	input logic [2:0] rd_a,
	input logic [2:0] rd_b,
	output lc3b_types::lc3b_word val_a,
	output lc3b_types::lc3b_word val_b,
	input logic wr_en,
	input logic [2:0] wr_dr,
	input lc3b_types::lc3b_word wr_val
);

	lc3b_types::lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_dr] <= wr_val;
		end
	end

	// Reads are combinational.
	assign val_a = regs[rd_a];
	assign val_b = regs[rd_b];

endmodule

`default_nettype wire

//--- hw/lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;

	// One instruction word, read as operate or shift format.
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [2:0] dr;
			logic [2:0] sr1;
			logic imm_flag;
			// Holds imm5, or sr2 in its low three bits.
			logic [4:0] low5;
		} opr;
		struct packed {
			logic [3:0] opcode;
			logic [2:0] dr;
			logic [2:0] sr1;
			logic arith;
			logic right;
			logic [3:0] amount;
		} shf;
	} lc3b_instr;

endpackage

`default_nettype wire

//--- hw/lc3b_defs.svh
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// Opcodes kept by this slice.
`define LC3B_OP_ADD 4'b0001
`define LC3B_OP_AND 4'b0101
`define LC3B_OP_XOR 4'b1001
`define LC3B_OP_SHF 4'b1101
`define LC3B_OP_MUL 4'b1010
`define LC3B_OP_DIV 4'b1011

// ALU operations.
`define LC3B_ALUOP_W 3
`define LC3B_ALU_ADD 3'd0
`define LC3B_ALU_AND 3'd1
`define LC3B_ALU_XOR 3'd2
`define LC3B_ALU_SLL 3'd3
`define LC3B_ALU_SRL 3'd4
`define LC3B_ALU_SRA 3'd5
`define LC3B_ALU_MUL 3'd6
`define LC3B_ALU_DIV 3'd7

// Operand B selects.
`define LC3B_OPB_W 2
`define LC3B_OPB_REG 2'd0
`define LC3B_OPB_IMM5 2'd1
`define LC3B_OPB_IMM4 2'd2

// Iterations of the multiply/divide unit.
`define LC3B_MD_CYCLES 16

`endif
